// File: all.f
smc_ahb_pkg.sv
smc_mem_pkg.sv
smc_req_if.sv
smc_ahb_lite_if.sv
smc_mac.sv
smc_ext_bus.sv
smc_top.sv
smc_sva.sv
tb_smc.sv

// File: Bender.yml
package:
  name: smc

sources:
  - smc_ahb_pkg.sv
  - smc_mem_pkg.sv
  - smc_req_if.sv
  - smc_ahb_lite_if.sv
  - smc_mac.sv
  - smc_ext_bus.sv
  - smc_top.sv
  - target: test
    files:
      - smc_sva.sv
      - tb_smc.sv

// File: tb_smc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_smc;
  import smc_ahb_pkg::*;
  import smc_mem_pkg::*;

  localparam int unsigned WAIT_STATES = 2;
  localparam int unsigned EXT_AW      = 20;
  localparam int          TIMEOUT     = 64;  // Cycles allowed per wait loop

  logic              hclk24;
  logic              n_sys_reset24;
  logic              hsel;
  ahb_addr_t         haddr;
  htrans_e           htrans;
  logic              hwrite;
  hsize_e            hsize;
  ahb_data_t         hwdata;
  logic              hready;
  ahb_data_t         hrdata;
  logic              hready_out;
  hresp_e            hresp;
  logic [EXT_AW-1:0] sram_addr;
  ext_data_t         sram_wdata;
  logic              sram_n_cs;
  logic              sram_n_oe;
  logic              sram_n_we;
  ext_data_t         sram_rdata;

  ext_data_t sram_mem [0:255];  // External SRAM contents
  ext_data_t exp_mem  [0:255];  // Expected contents from the lane rule
  int        errors;
  int        checks;
  int        tests;
  int        failed_tests;
  int        cs_low_cycles;     // Clock edges seen with chip select active

  smc_top #(
    .WAIT_STATES (WAIT_STATES),
    .EXT_AW      (EXT_AW)
  ) dut0 (
    .hclk24        (hclk24),
    .n_sys_reset24 (n_sys_reset24),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hsize         (hsize),
    .hwdata        (hwdata),
    .hready        (hready),
    .hrdata        (hrdata),
    .hready_out    (hready_out),
    .hresp         (hresp),
    .sram_addr     (sram_addr),
    .sram_wdata    (sram_wdata),
    .sram_n_cs     (sram_n_cs),
    .sram_n_oe     (sram_n_oe),
    .sram_n_we     (sram_n_we),
    .sram_rdata    (sram_rdata)
  );

  always #50 hclk24 = ~hclk24;  // 100 ns period

  // ----------------------------------------------------------------------
  // 256-byte SRAM model
  // ----------------------------------------------------------------------
  // Asynchronous read, driven only while selected and enabled
  assign sram_rdata = ((sram_n_cs === 1'b0) && (sram_n_oe === 1'b0)) ?
                      sram_mem[sram_addr[7:0]] : 'x;

  always @(posedge sram_n_we)
  begin
    if (n_sys_reset24 === 1'b1)  // Ignore the reset edge out of X
    begin
      sram_mem[sram_addr[7:0]] <= sram_wdata;
    end
  end

  always @(posedge hclk24)
  begin
    if (sram_n_cs === 1'b0)
    begin
      cs_low_cycles <= cs_low_cycles + 1;
    end
  end

  // Start pattern that depends on every address bit
  function automatic ext_data_t fill_byte(input int unsigned a);
    fill_byte = 8'(a * 7) ^ 8'hC3;
  endfunction

  function automatic ahb_data_t sram_word(input ahb_addr_t a);
    sram_word = {sram_mem[a[7:0] + 3], sram_mem[a[7:0] + 2],
                 sram_mem[a[7:0] + 1], sram_mem[a[7:0]]};
  endfunction

  // Lane k of the AHB word is bits 8k up
  task automatic model_write(input ahb_addr_t addr, input hsize_e size, input ahb_data_t wdata);
    int unsigned k;
    for (k = 0; k < (1 << int'(size)); k++)
    begin
      exp_mem[addr[7:0] + k] = wdata[8*(addr[1:0] + k) +: 8];
    end
  endtask

  function automatic ahb_data_t model_read(input ahb_addr_t addr, input hsize_e size);
    ahb_data_t   w;
    int unsigned k;
    w = '0;  // Lanes not accessed stay zero
    for (k = 0; k < (1 << int'(size)); k++)
    begin
      w[8*(addr[1:0] + k) +: 8] = exp_mem[addr[7:0] + k];
    end
    model_read = w;
  endfunction

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_data(input string name, input ahb_data_t got, input ahb_data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input hresp_e got, input hresp_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t ns: %s = %s (%b), expected %s", $time, name, got.name(), got,
               exp.name());
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors == err0)
    begin
      $display("Test %s: ok", name);
    end
    else
    begin
      failed_tests++;
      $display("Test %s: %0d errors", name, errors - err0);
    end
  endtask

  // ----------------------------------------------------------------------
  // AHB master
  // ----------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge hclk24);
    #5;  // Drive point
  endtask

  task automatic addr_phase(input logic sel, input htrans_e trans, input logic wr,
                            input hsize_e size, input ahb_addr_t addr);
    hsel   = sel;
    htrans = trans;
    hwrite = wr;
    hsize  = size;
    haddr  = addr;
    next_cycle();
  endtask

  // Returns in the cycle where hready_out is high
  task automatic data_phase(input ahb_data_t wdata, output ahb_data_t rdata,
                            output hresp_e resp, output int low);
    low    = 0;
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    hwdata = wdata;  // Held for the whole data phase
    while (hready_out !== 1'b1)
    begin
      low++;
      if (low > TIMEOUT)
      begin
        stop_on_timeout("hready_out stayed low in a data phase");
      end
      next_cycle();
    end
    rdata = hrdata;
    resp  = hresp;
  endtask

  task automatic finish_xfer(input logic wr, input hsize_e size, input ahb_addr_t addr,
                             input ahb_data_t wdata);
    ahb_data_t rdata;
    hresp_e    resp;
    int        low;
    int        nbytes;
    nbytes = 1 << int'(size);
    data_phase(wdata, rdata, resp, low);
    check_resp("hresp", resp, HRESP_OKAY);
    // Pending cycle then SETUP, strobes and HOLD per byte, plus WDATA on writes
    check_count("hready_out low cycles", low, 1 + nbytes * (3 + WAIT_STATES) + int'(wr));
    if (wr)
    begin
      model_write(addr, size, wdata);
    end
    else
    begin
      check_data("hrdata", rdata, model_read(addr, size));
    end
  endtask

  task automatic single_xfer(input logic wr, input hsize_e size, input ahb_addr_t addr,
                             input ahb_data_t wdata);
    addr_phase(1'b1, HTRANS_NONSEQ, wr, size, addr);
    finish_xfer(wr, size, addr, wdata);
    next_cycle();
  endtask

  task automatic pick_xfer(output logic wr, output hsize_e size, output ahb_addr_t addr,
                           output ahb_data_t wdata);
    wr    = $urandom() % 2;
    size  = hsize_e'($urandom() % 3);
    addr  = ($urandom() % 256) & ~((32'd1 << int'(size)) - 32'd1);  // Aligned
    wdata = $urandom();
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_reset_state();
    int err0;
    err0 = errors;
    check_bit("hready_out", hready_out, 1'b1);
    check_resp("hresp", hresp, HRESP_OKAY);
    check_bit("sram_n_cs", sram_n_cs, 1'b1);
    check_bit("sram_n_oe", sram_n_oe, 1'b1);
    check_bit("sram_n_we", sram_n_we, 1'b1);
    report_test("reset state", err0);
  endtask

  task automatic test_word_rw();
    int        err0;
    ahb_data_t data;
    err0 = errors;
    data = $urandom();
    single_xfer(1'b1, HSIZE_WORD, 32'h10, data);
    single_xfer(1'b0, HSIZE_WORD, 32'h10, '0);  // Model now holds data
    check_data("sram word 0x10", sram_word(32'h10), data);
    report_test("word write and read", err0);
  endtask

  task automatic test_lanes();
    int          err0;
    int unsigned k;
    err0 = errors;
    single_xfer(1'b1, HSIZE_WORD, 32'h20, $urandom());
    for (k = 0; k < 4; k++)
    begin
      single_xfer(1'b1, HSIZE_BYTE, 32'h20 + k, $urandom());
      single_xfer(1'b0, HSIZE_WORD, 32'h20, '0);
      check_data("sram word 0x20", sram_word(32'h20), model_read(32'h20, HSIZE_WORD));
    end
    for (k = 0; k < 4; k += 2)
    begin
      single_xfer(1'b1, HSIZE_HALF, 32'h20 + k, $urandom());
      single_xfer(1'b0, HSIZE_WORD, 32'h20, '0);
      check_data("sram word 0x20", sram_word(32'h20), model_read(32'h20, HSIZE_WORD));
    end
    report_test("byte and halfword lanes", err0);
  endtask

  task automatic misaligned_case(input hsize_e size, input ahb_addr_t addr);
    int cs0;
    cs0 = cs_low_cycles;
    addr_phase(1'b1, HTRANS_NONSEQ, 1'b1, size, addr);
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    hwdata = $urandom();
    check_bit("hready_out", hready_out, 1'b0);  // First ERROR cycle
    check_resp("hresp", hresp, HRESP_ERROR);
    next_cycle();
    check_bit("hready_out", hready_out, 1'b1);
    check_resp("hresp", hresp, HRESP_ERROR);
    next_cycle();
    check_resp("hresp", hresp, HRESP_OKAY);
    repeat (4) next_cycle();
    check_count("chip select cycles", cs_low_cycles - cs0, 0);
    check_data("sram word", sram_word({addr[31:2], 2'b00}),
               model_read({addr[31:2], 2'b00}, HSIZE_WORD));  // Unchanged
  endtask

  task automatic test_misaligned();
    int err0;
    err0 = errors;
    misaligned_case(HSIZE_HALF, 32'h31);
    misaligned_case(HSIZE_WORD, 32'h42);
    report_test("misaligned", err0);
  endtask

  task automatic no_xfer_case(input logic sel, input htrans_e trans);
    int cs0;
    cs0 = cs_low_cycles;
    addr_phase(sel, trans, 1'b1, HSIZE_WORD, 32'h50);
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    check_bit("hready_out", hready_out, 1'b1);  // Zero wait
    check_resp("hresp", hresp, HRESP_OKAY);
    repeat (4) next_cycle();
    check_count("chip select cycles", cs_low_cycles - cs0, 0);
  endtask

  task automatic test_no_xfer();
    int err0;
    err0 = errors;
    no_xfer_case(1'b1, HTRANS_IDLE);
    no_xfer_case(1'b1, HTRANS_BUSY);
    no_xfer_case(1'b0, HTRANS_NONSEQ);
    no_xfer_case(1'b0, HTRANS_SEQ);
    report_test("idle, busy and unselected", err0);
  endtask

  task automatic test_back_to_back();
    int        err0;
    int        i;
    logic      wr;
    hsize_e    size;
    ahb_addr_t addr;
    ahb_data_t wdata;
    err0 = errors;
    pick_xfer(wr, size, addr, wdata);
    addr_phase(1'b1, HTRANS_NONSEQ, wr, size, addr);
    for (i = 0; i < 16; i++)
    begin
      finish_xfer(wr, size, addr, wdata);  // Ends in the DONE cycle
      if (i < 15)
      begin
        pick_xfer(wr, size, addr, wdata);
        addr_phase(1'b1, ($urandom() % 2) ? HTRANS_SEQ : HTRANS_NONSEQ, wr, size, addr);
      end
      else
      begin
        next_cycle();
      end
    end
    report_test("back to back", err0);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    int a;
    void'($urandom(85774));
    hclk24        = 1'b0;
    n_sys_reset24 = 1'b0;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = HTRANS_IDLE;
    hwrite        = 1'b0;
    hsize         = HSIZE_BYTE;
    hwdata        = '0;
    hready        = 1'b1;  // Single slave so the bus is always ready
    errors        = 0;
    checks        = 0;
    tests         = 0;
    failed_tests  = 0;
    cs_low_cycles = 0;
    for (a = 0; a < 256; a++)
    begin
      sram_mem[a] = fill_byte(a);
      exp_mem[a]  = fill_byte(a);
    end
    repeat (16) @(posedge hclk24);
    #5;
    n_sys_reset24 = 1'b1;
    next_cycle();
    test_reset_state();
    test_word_rw();
    test_lanes();
    test_misaligned();
    test_no_xfer();
    test_back_to_back();
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, failed_tests, checks, errors, dut0.u_sva.fails);
    if ((errors == 0) && (dut0.u_sva.fails == 0))
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: smc_sva.sv
`timescale 1ns/1ps
`default_nettype none

// Response and strobe checks bound into the top level
module smc_sva (
  input logic                hclk24,
  input logic                n_sys_reset24,
  input logic                hready_out,
  input smc_ahb_pkg::hresp_e hresp,
  input logic                sram_n_cs,
  input logic                sram_n_oe,
  input logic                sram_n_we
);
  import smc_ahb_pkg::*;

  logic        err;
  int unsigned fails;  // Failed assertions so far

  assign err = (hresp == HRESP_ERROR);

  initial
  begin
    fails = 0;
  end

  // ----------------------------------------------------------------------
  // Two-cycle AHB ERROR response
  // ----------------------------------------------------------------------
  a_err_second: assert property (@(posedge hclk24) disable iff (!n_sys_reset24)
    (err && !hready_out) |=> (err && hready_out))
    else
    begin
      fails++;
      $error("ERROR response without a second cycle with hready_out high");
    end

  // A ready ERROR cycle always follows a waited one
  a_err_first: assert property (@(posedge hclk24) disable iff (!n_sys_reset24)
    (err && hready_out) |-> $past(err && !hready_out))
    else
    begin
      fails++;
      $error("ERROR response with hready_out high in its first cycle");
    end

  // ----------------------------------------------------------------------
  // SRAM strobes
  // ----------------------------------------------------------------------
  a_strobe_cs: assert property (@(posedge hclk24) disable iff (!n_sys_reset24)
    sram_n_cs |-> (sram_n_oe && sram_n_we))
    else
    begin
      fails++;
      $error("SRAM strobe active with chip select inactive");
    end

endmodule

bind smc_top smc_sva u_sva (
  .hclk24        (hclk24),
  .n_sys_reset24 (n_sys_reset24),
  .hready_out    (hready_out),
  .hresp         (hresp),
  .sram_n_cs     (sram_n_cs),
  .sram_n_oe     (sram_n_oe),
  .sram_n_we     (sram_n_we)
);

`default_nettype wire

// File: smc_top.sv
`timescale 1ns/1ps
`default_nettype none

// Static memory controller slice, AHB-Lite slave on one 8-bit SRAM
module smc_top #(
  parameter int unsigned WAIT_STATES = smc_mem_pkg::DEFAULT_WAIT_STATES,
  parameter int unsigned EXT_AW      = $bits(smc_mem_pkg::ext_addr_t)
) (
  input  logic                   hclk24,
  input  logic                   n_sys_reset24,
  // AHB side
  input  logic                   hsel,
  input  smc_ahb_pkg::ahb_addr_t haddr,
  input  smc_ahb_pkg::htrans_e   htrans,
  input  logic                   hwrite,
  input  smc_ahb_pkg::hsize_e    hsize,
  input  smc_ahb_pkg::ahb_data_t hwdata,
  input  logic                   hready,
  output smc_ahb_pkg::ahb_data_t hrdata,
  output logic                   hready_out,
  output smc_ahb_pkg::hresp_e    hresp,
  // SRAM side
  output logic [EXT_AW-1:0]      sram_addr,
  output smc_mem_pkg::ext_data_t sram_wdata,
  output logic                   sram_n_cs,
  output logic                   sram_n_oe,
  output logic                   sram_n_we,
  input  smc_mem_pkg::ext_data_t sram_rdata
);

  smc_req_if                    u_req_if ();
  smc_ext_if #(.EXT_AW(EXT_AW)) u_ext_if ();

  // ----------------------------------------------------------------------
  // Front end, controller, bus driver
  // ----------------------------------------------------------------------
  smc_ahb_lite_if u_ahb_if (
    .hclk24        (hclk24),
    .n_sys_reset24 (n_sys_reset24),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hsize         (hsize),
    .hready        (hready),
    .rd_word       (u_req_if.read_data),  // Gated word from the controller
    .hrdata        (hrdata),
    .hready_out    (hready_out),
    .hresp         (hresp),
    .req           (u_req_if.front)
  );

  smc_mac #(
    .WAIT_STATES (WAIT_STATES),
    .EXT_AW      (EXT_AW)
  ) u_mac (
    .hclk24        (hclk24),
    .n_sys_reset24 (n_sys_reset24),
    .hwdata        (hwdata),  // Bypasses the request, arrives a cycle later
    .req           (u_req_if.ctrl),
    .ext           (u_ext_if.ctrl)
  );

  smc_ext_bus #(
    .EXT_AW (EXT_AW)
  ) u_ext_bus (
    .hclk24        (hclk24),
    .n_sys_reset24 (n_sys_reset24),
    .sram_rdata    (sram_rdata),
    .sram_addr     (sram_addr),
    .sram_wdata    (sram_wdata),
    .sram_n_cs     (sram_n_cs),
    .sram_n_oe     (sram_n_oe),
    .sram_n_we     (sram_n_we),
    .read_data     (u_ext_if.rd_word),  // Returned to the controller
    .ext           (u_ext_if.bus)
  );

endmodule

`default_nettype wire

// File: smc_ext_bus.sv
`timescale 1ns/1ps
`default_nettype none

// External 8-bit SRAM bus, registered strobes and lane steering
module smc_ext_bus #(
  parameter int unsigned EXT_AW = smc_mem_pkg::DEFAULT_EXT_AW
) (
  input  logic                   hclk24,
  input  logic                   n_sys_reset24,
  input  smc_mem_pkg::ext_data_t sram_rdata,
  output logic [EXT_AW-1:0]      sram_addr,
  output smc_mem_pkg::ext_data_t sram_wdata,
  output logic                   sram_n_cs,
  output logic                   sram_n_oe,
  output logic                   sram_n_we,
  output smc_ahb_pkg::ahb_data_t read_data,  // Assembled read word
  smc_ext_if.bus                 ext
);
  import smc_mem_pkg::*;

  ext_data_t [3:0] rd_lane_q;  // Read bytes by lane
  logic            rd_cap;     // Last strobe cycle of a read

  // ----------------------------------------------------------------------
  // Strobes
  // ----------------------------------------------------------------------
  // All change on the clock edge only
  always_ff @(posedge hclk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
    begin
      sram_n_cs <= 1'b1;
      sram_n_oe <= 1'b1;
      sram_n_we <= 1'b1;
    end
    else
    begin
      sram_n_cs <= ~ext.cs_en;
      sram_n_oe <= ~(ext.strobe & ~ext.wr);
      sram_n_we <= ~(ext.strobe & ext.wr);  // Rising edge writes the SRAM
    end
  end

  // Address and write byte, stable over the whole strobe
  always_ff @(posedge hclk24)
  begin
    sram_addr  <= ext.byte_addr;
    sram_wdata <= ext.wbyte_src[8*ext.lane +: 8];  // Lane k from bits 8k up
  end

  // ----------------------------------------------------------------------
  // Read assembly
  // ----------------------------------------------------------------------
  // OE still low but the controller already in HOLD
  assign rd_cap = ~sram_n_oe & ~ext.strobe;

  always_ff @(posedge hclk24)
  begin
    if (rd_cap)
    begin
      rd_lane_q[ext.lane] <= sram_rdata;
    end
    else if (!ext.cs_en)
    begin
      rd_lane_q <= '0;  // Untouched lanes read as zero
    end
  end

  assign read_data = rd_lane_q;

endmodule

`default_nettype wire

// File: smc_mac.sv
`timescale 1ns/1ps
`default_nettype none

// Memory access controller, one AHB transfer as 1, 2 or 4 byte cycles
module smc_mac #(
  parameter int unsigned WAIT_STATES = smc_mem_pkg::DEFAULT_WAIT_STATES,
  parameter int unsigned EXT_AW      = smc_mem_pkg::DEFAULT_EXT_AW
) (
  input  logic                   hclk24,
  input  logic                   n_sys_reset24,
  input  smc_ahb_pkg::ahb_data_t hwdata,  // Data phase write word
  smc_req_if.ctrl                req,
  smc_ext_if.ctrl                ext
);
  import smc_ahb_pkg::*;
  import smc_mem_pkg::*;

  mac_state_e        state;
  mac_state_e        state_nxt;
  logic              pend;         // Request latched, not started
  logic              wr_q;         // Direction of the transfer
  logic [1:0]        lane_q;       // Lane of the current byte
  logic [1:0]        byte_left;    // Bytes after the current one
  logic [3:0]        wait_cnt;     // Strobe cycles still to go
  logic [EXT_AW-3:0] word_addr_q;  // External word address
  ahb_data_t         wdata_q;      // Captured write word

  // Index of the last byte for a given size
  function automatic logic [1:0] last_byte(input xfer_size_t size);
    case (size)
      2'b00:   last_byte = 2'd0;
      2'b01:   last_byte = 2'd1;
      default: last_byte = 2'd3;  // Word
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      MAC_IDLE:
      begin
        if (pend)
        begin
          state_nxt = wr_q ? MAC_WDATA : MAC_SETUP;
        end
      end
      MAC_WDATA:  state_nxt = MAC_SETUP;
      MAC_SETUP:  state_nxt = MAC_STROBE;
      MAC_STROBE:
      begin
        if (wait_cnt == 4'd0)
        begin
          state_nxt = MAC_HOLD;  // Wait states used up
        end
      end
      MAC_HOLD:   state_nxt = (byte_left == 2'd0) ? MAC_DONE : MAC_SETUP;
      MAC_DONE:   state_nxt = MAC_IDLE;
      default:    state_nxt = MAC_IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------
  always_ff @(posedge hclk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
    begin
      state     <= MAC_IDLE;
      pend      <= 1'b0;
      wr_q      <= 1'b0;
      lane_q    <= 2'd0;
      byte_left <= 2'd0;
      wait_cnt  <= 4'd0;
    end
    else
    begin
      state <= state_nxt;
      if (req.new_access)
      begin
        // Only seen in IDLE or DONE
        pend      <= 1'b1;
        wr_q      <= req.n_read;
        lane_q    <= req.addr[1:0];         // First lane from the address
        byte_left <= last_byte(req.xfer_size);
      end
      else if ((state == MAC_IDLE) && pend)
      begin
        pend <= 1'b0;  // Transfer started
      end

      if (state == MAC_SETUP)
      begin
        wait_cnt <= 4'(WAIT_STATES);
      end
      else if ((state == MAC_STROBE) && (wait_cnt != 4'd0))
      begin
        wait_cnt <= wait_cnt - 4'd1;
      end

      if ((state == MAC_HOLD) && (byte_left != 2'd0))
      begin
        byte_left <= byte_left - 2'd1;
        lane_q    <= lane_q + 2'd1;  // Next byte up
      end
    end
  end

  // ----------------------------------------------------------------------
  // Payload
  // ----------------------------------------------------------------------
  always_ff @(posedge hclk24)
  begin
    if (req.new_access)
    begin
      word_addr_q <= req.addr[EXT_AW-1:2];
    end
    if (state == MAC_WDATA)
    begin
      wdata_q <= hwdata;  // Data phase held while ready is low
    end
  end

  // Byte cycle control to the bus driver
  assign ext.byte_addr = {word_addr_q, lane_q};
  assign ext.lane      = lane_q;
  assign ext.wr        = wr_q;
  assign ext.cs_en     = (state == MAC_SETUP) | (state == MAC_STROBE) |
                         (state == MAC_HOLD);
  assign ext.strobe    = (state == MAC_STROBE);
  assign ext.wbyte_src = wdata_q;

  // Status back to the front end
  assign req.smc_done  = (state == MAC_HOLD) | (state == MAC_DONE);
  assign req.mac_done  = (state == MAC_DONE);
  assign req.smc_idle  = ((state == MAC_IDLE) & ~pend) | (state == MAC_DONE);
  assign req.read_data = ((state == MAC_DONE) && !wr_q) ? ext.rd_word : '0;  // Reads only

endmodule

`default_nettype wire

// File: smc_ahb_lite_if.sv
`timescale 1ns/1ps
`default_nettype none

// AHB-Lite slave front end of the static memory controller
module smc_ahb_lite_if (
  input  logic                  hclk24,
  input  logic                  n_sys_reset24,
  input  logic                  hsel,        // Slave select from decoder
  input  smc_ahb_pkg::ahb_addr_t haddr,
  input  smc_ahb_pkg::htrans_e  htrans,
  input  logic                  hwrite,
  input  smc_ahb_pkg::hsize_e   hsize,
  input  logic                  hready,      // Muxed bus ready
  input  smc_ahb_pkg::ahb_data_t rd_word,    // Read word from the controller
  output smc_ahb_pkg::ahb_data_t hrdata,
  output logic                  hready_out,
  output smc_ahb_pkg::hresp_e   hresp,
  smc_req_if.front              req
);
  import smc_ahb_pkg::*;

  logic active;      // NONSEQ or SEQ to this slave
  logic misaligned;  // Size and address disagree
  logic mis_err;     // Misaligned transfer sampled
  logic new_acc;     // Valid aligned transfer sampled
  logic r_ready;     // Registered part of HREADY
  logic r_hresp;     // Second cycle of ERROR pending
  logic ctrl_done;   // Controller finished the transfer

  // ----------------------------------------------------------------------
  // Address phase decode
  // ----------------------------------------------------------------------
  assign active = hsel & ((htrans == HTRANS_NONSEQ) | (htrans == HTRANS_SEQ));

  // Half on odd byte, word off a word boundary
  always_comb
  begin
    misaligned = 1'b0;
    if ((hsize == HSIZE_HALF) && haddr[0])
    begin
      misaligned = 1'b1;
    end
    else if ((hsize == HSIZE_WORD) && (haddr[1:0] != 2'b00))
    begin
      misaligned = 1'b1;
    end
  end

  assign mis_err = active & hready & misaligned;  // No memory cycle for these
  assign new_acc = active & hready & ~misaligned & req.smc_idle;

  // Request straight from the address phase
  assign req.new_access = new_acc;
  assign req.addr       = haddr;
  assign req.xfer_size  = hsize[1:0];
  assign req.n_read     = hwrite;  // High means write

  assign ctrl_done = req.smc_done & req.mac_done;

  // ----------------------------------------------------------------------
  // Response
  // ----------------------------------------------------------------------
  // ERROR lasts two cycles, ready low then high
  always_ff @(posedge hclk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
    begin
      hresp   <= HRESP_OKAY;
      r_hresp <= 1'b0;
    end
    else if (mis_err)
    begin
      hresp   <= HRESP_ERROR;
      r_hresp <= 1'b1;
    end
    else if (r_hresp)
    begin
      hresp   <= HRESP_ERROR;  // Second error cycle
      r_hresp <= 1'b0;
    end
    else
    begin
      hresp   <= HRESP_OKAY;
    end
  end

  // ----------------------------------------------------------------------
  // Ready
  // ----------------------------------------------------------------------
  // Low from an accepted or faulty transfer until the controller
  // or the error sequence releases it
  always_ff @(posedge hclk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
    begin
      r_ready <= 1'b1;
    end
    else if (new_acc | mis_err)
    begin
      r_ready <= 1'b0;
    end
    else if (r_hresp | ctrl_done)
    begin
      r_ready <= 1'b1;  // Idle, busy and unselected keep it high
    end
  end

  assign hready_out = r_ready | ctrl_done;  // DONE cycle ends the wait

  assign hrdata = rd_word;

endmodule

`default_nettype wire

// File: smc_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// One accepted AHB request, front end to controller
interface smc_req_if;
  import smc_ahb_pkg::*;
  import smc_mem_pkg::*;

  logic       new_access;  // Single cycle start pulse
  ahb_addr_t  addr;        // Address phase address
  xfer_size_t xfer_size;   // Byte, half or word
  logic       n_read;      // High for a write
  logic       smc_done;    // End of a byte cycle
  logic       mac_done;    // Last byte of the transfer
  logic       smc_idle;    // Controller can take a request
  ahb_data_t  read_data;   // Assembled read word

  // Read word reaches the front end through its own port
  modport front (output new_access, addr, xfer_size, n_read,
                 input  smc_done, mac_done, smc_idle);
  modport ctrl  (input  new_access, addr, xfer_size, n_read,
                 output smc_done, mac_done, smc_idle, read_data);
endinterface

// Byte cycle control, controller to external bus driver
interface smc_ext_if #(
  parameter int unsigned EXT_AW = smc_mem_pkg::DEFAULT_EXT_AW
);
  import smc_ahb_pkg::*;

  logic [EXT_AW-1:0] byte_addr;  // Current external byte
  logic [1:0]        lane;       // Byte lane within the AHB word
  logic              wr;         // Write cycle
  logic              cs_en;      // Chip select wanted
  logic              strobe;     // OE or WE wanted
  ahb_data_t         wbyte_src;  // Captured write word
  ahb_data_t         rd_word;    // Assembled read word back from the bus

  modport ctrl (output byte_addr, lane, wr, cs_en, strobe, wbyte_src,
                input  rd_word);
  modport bus  (input  byte_addr, lane, wr, cs_en, strobe, wbyte_src);
endinterface

`default_nettype wire

// File: smc_mem_pkg.sv
`default_nettype none

// Memory side types for the controller and the external bus
package smc_mem_pkg;

  // ----------------------------------------------------------------------
  // External cycle defaults
  // ----------------------------------------------------------------------
  localparam int unsigned DEFAULT_EXT_AW      = 20;  // 1 MB byte space
  localparam int unsigned DEFAULT_WAIT_STATES = 2;   // Extra strobe cycles per byte

  typedef logic [DEFAULT_EXT_AW-1:0] ext_addr_t;  // External byte address
  typedef logic [7:0]                ext_data_t;  // One SRAM byte

  // Low two bits of HSIZE, as seen by the controller
  typedef logic [1:0] xfer_size_t;

  // ----------------------------------------------------------------------
  // Controller FSM
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    MAC_IDLE   = 3'd0,  // Waiting, or request pending
    MAC_WDATA  = 3'd1,  // Write data capture
    MAC_SETUP  = 3'd2,  // Address and chip select out
    MAC_STROBE = 3'd3,  // OE or WE active
    MAC_HOLD   = 3'd4,  // Strobe released, address held
    MAC_DONE   = 3'd5   // Last byte finished, AHB ready
  } mac_state_e;

endpackage

`default_nettype wire

// File: smc_ahb_pkg.sv
`default_nettype none

// AHB-Lite protocol types, shared by the front end, top and testbench
package smc_ahb_pkg;

  // ----------------------------------------------------------------------
  // Bus words
  // ----------------------------------------------------------------------
  typedef logic [31:0] ahb_addr_t;  // Byte address
  typedef logic [31:0] ahb_data_t;  // Read and write data

  // ----------------------------------------------------------------------
  // Control encodings
  // ----------------------------------------------------------------------
  // Transfer type, SEQ handled like NONSEQ here
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,  // 8 bit
    HSIZE_HALF = 3'b001,  // 16 bit
    HSIZE_WORD = 3'b010   // 32 bit
  } hsize_e;

  // Only OKAY and ERROR are ever returned
  typedef enum logic [1:0] {
    HRESP_OKAY  = 2'b00,
    HRESP_ERROR = 2'b01
  } hresp_e;

endpackage

`default_nettype wire
